// ==== Makefile ====
# Verilator build of the CAN register block testbench

VERILATOR ?= verilator
TOP       ?= tb_can_regs
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/can_command_ctrl.sv ====
`timescale 1ns/1ps

module can_command_ctrl
  import can_regs_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  host_wr_t      host_wr,
  input  mode_cfg_t     mode_cfg,
  input  core_status_t  core_status,
  output core_ctrl_t    core_ctrl,
  output status_flags_t status_flags
);

  logic [4:0]    cmd_q;
  logic [4:0]    cmd_clr;
  logic          self_rx_q;
  logic          single_shot_q;
  logic          tx_req;
  logic          abort;
  logic          tx_done;
  logic          tx_successful_q;
  logic          overrun_q;
  status_flags_t flags_q;

  assign tx_req  = cmd_q[0] | cmd_q[4];
  // Abort is ignored while a request is pending
  assign abort   = cmd_q[1] & ~tx_req;
  // Transmitter leaves its active state
  assign tx_done = ~core_status.tx_state & core_status.tx_state_q;

  //////////////////////////////////////////////////////////////////////
  // Self-clearing command bits
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    cmd_clr[0] = cmd_q[0] & core_status.sample_point;
    cmd_clr[1] = core_status.sample_point & (tx_req | (abort & ~core_status.transmitting));
    // Release and clear overrun live for a single cycle
    cmd_clr[2] = |cmd_q[3:2];
    cmd_clr[3] = |cmd_q[3:2];
    cmd_clr[4] = cmd_q[4] & core_status.sample_point;
    cmd_clr = cmd_clr | {5{mode_cfg.reset_mode}};
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      cmd_q <= '0;
    else
      for (int i = 0; i < 5; i++)
      begin
        if (cmd_clr[i])
          cmd_q[i] <= 1'b0;
        else if (host_wr.command)
          cmd_q[i] <= host_wr.data[i];
      end
  end

  // Self reception and single shot hold until the frame ends
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      self_rx_q     <= 1'b0;
      single_shot_q <= 1'b0;
    end
    else
    begin
      if (cmd_q[4] & ~cmd_q[0])
        self_rx_q <= 1'b1;
      else if (tx_done)
        self_rx_q <= 1'b0;
      // Request together with abort means one attempt only
      if (tx_req & cmd_q[1] & core_status.sample_point)
        single_shot_q <= 1'b1;
      else if (tx_done)
        single_shot_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Status flags
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      tx_successful_q <= 1'b0;
      overrun_q       <= 1'b0;
      flags_q         <= 4'b1100;
    end
    else
    begin
      tx_successful_q <= core_status.tx_successful;
      overrun_q       <= core_status.overrun;
      if ((core_status.tx_successful & ~tx_successful_q) | abort)
        flags_q.transmission_complete <= 1'b1;
      else if (tx_req)
        flags_q.transmission_complete <= 1'b0;
      // Buffer frees once the core has nothing left to send
      if (tx_req)
        flags_q.transmit_buffer_status <= 1'b0;
      else if (mode_cfg.reset_mode | ~core_status.need_to_tx)
        flags_q.transmit_buffer_status <= 1'b1;
      if (core_status.overrun & ~overrun_q)
        flags_q.overrun_status <= 1'b1;
      else if (mode_cfg.reset_mode | cmd_q[3])
        flags_q.overrun_status <= 1'b0;
      if (mode_cfg.reset_mode | cmd_q[2])
        flags_q.receive_buffer_status <= 1'b0;
      else if (~core_status.info_empty)
        flags_q.receive_buffer_status <= 1'b1;
    end
  end

  always_comb
  begin
    core_ctrl.tx_request = tx_req;
    core_ctrl.abort_tx = abort;
    core_ctrl.release_buffer = cmd_q[2];
    core_ctrl.clear_data_overrun = cmd_q[3];
    core_ctrl.self_rx_request = self_rx_q;
    core_ctrl.single_shot_transmission = single_shot_q;
  end

  assign status_flags = flags_q;

endmodule

// ==== logic/can_host_port.sv ====
`timescale 1ns/1ps
`include "can_regs_settings.svh"

module can_host_port
  import can_regs_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  re,
  input  logic                  we,
  input  logic [7:0]            addr_read,
  input  logic [7:0]            addr_write,
  input  logic [`CAN_DATA_W-1:0] data_in,
  output logic [`CAN_DATA_W-1:0] data_out,
  input  mode_cfg_t             mode_cfg,
  input  acc_filter_t           acc_filter,
  input  status_flags_t         status_flags,
  input  core_status_t          core_status,
  input  logic [7:0]            irq_flags,
  output host_wr_t              host_wr,
  output logic                  read_irq
);

  logic      ext;
  logic      rm;
  can_byte_t status_byte;

  assign ext = mode_cfg.extended_mode;
  assign rm  = mode_cfg.reset_mode;

  // Strobe towards the interrupt block while the interrupt register is read
  assign read_irq = re & (addr_read == `CAN_ADDR_IRQ);

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    host_wr = '0;
    host_wr.data = data_in;
    host_wr.mode = we & (addr_write == `CAN_ADDR_MODE);
    // Basic layout follows every basic mode write
    host_wr.mode_basic = host_wr.mode & ~ext;
    // Extended layout is locked outside reset mode
    host_wr.mode_ext = host_wr.mode & ext & rm;
    host_wr.command = we & (addr_write == `CAN_ADDR_COMMAND);
    host_wr.irq_en = we & ext & (addr_write == `CAN_ADDR_IRQ_EN);
    host_wr.clkdiv_lo = we & (addr_write == `CAN_ADDR_CLKDIV);
    host_wr.clkdiv_hi = host_wr.clkdiv_lo & rm;
    // Code and mask 0 exist in both modes at different addresses
    host_wr.acc_code[0] = we & rm & (ext ? addr_write == `CAN_ADDR_ACC_CODE0_EXT
                                         : addr_write == `CAN_ADDR_ACC_CODE0_BASIC);
    host_wr.acc_mask[0] = we & rm & (ext ? addr_write == `CAN_ADDR_ACC_MASK0_EXT
                                         : addr_write == `CAN_ADDR_ACC_MASK0_BASIC);
    // Codes and masks 1 to 3 only in extended mode
    for (int i = 1; i < 4; i++)
    begin
      host_wr.acc_code[i] = we & rm & ext & (addr_write == `CAN_ADDR_ACC_CODE0_EXT + i);
      host_wr.acc_mask[i] = we & rm & ext & (addr_write == `CAN_ADDR_ACC_MASK0_EXT + i);
    end
  end

  // Upper nibble straight from the core, lower from the held flags
  assign status_byte = {core_status.node_bus_off, core_status.error_status,
                        core_status.transmit_status, core_status.receive_status,
                        status_flags};

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    data_out = 8'h00;
    if (ext)
    begin
      case (addr_read) inside
        `CAN_ADDR_MODE:   data_out = {4'h0, mode_cfg.mode[3:0]};
        `CAN_ADDR_STATUS: data_out = status_byte;
        `CAN_ADDR_IRQ:    data_out = irq_flags;
        `CAN_ADDR_IRQ_EN: data_out = mode_cfg.irq_en;
        [8'd16:8'd19]:    data_out = acc_filter.code[addr_read[1:0]];
        [8'd20:8'd23]:    data_out = acc_filter.mask[addr_read[1:0]];
        `CAN_ADDR_CLKDIV: data_out = mode_cfg.clock_div;
        default:          data_out = 8'h00;
      endcase
    end
    else
    begin
      case (addr_read) inside
        `CAN_ADDR_MODE:    data_out = {3'b001, mode_cfg.mode[4:0]};
        `CAN_ADDR_COMMAND: data_out = `CAN_BASIC_FILL;
        `CAN_ADDR_STATUS:  data_out = status_byte;
        `CAN_ADDR_IRQ:     data_out = {4'he, irq_flags[3:0]};
        // Acceptance bytes hidden once the controller runs
        `CAN_ADDR_ACC_CODE0_BASIC: data_out = rm ? acc_filter.code[0] : `CAN_BASIC_FILL;
        `CAN_ADDR_ACC_MASK0_BASIC: data_out = rm ? acc_filter.mask[0] : `CAN_BASIC_FILL;
        [8'd10:8'd19]:     data_out = `CAN_BASIC_FILL;
        `CAN_ADDR_CLKDIV:  data_out = mode_cfg.clock_div;
        default:           data_out = 8'h00;
      endcase
    end
  end

endmodule

// ==== logic/can_irq_ctrl.sv ====
`timescale 1ns/1ps

module can_irq_ctrl
  import can_regs_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  mode_cfg_t     mode_cfg,
  input  core_status_t  core_status,
  input  core_ctrl_t    core_ctrl,
  input  status_flags_t status_flags,
  input  logic          read_irq,
  output logic [7:0]    irq_flags,
  output logic          irq_n
);

  logic ext;
  logic rm;
  logic ovr_en;
  logic err_en;
  logic tx_en;
  logic rx_en;
  // Registered copies for edge detection
  logic tbs_q;
  logic overrun_q;
  logic error_status_q;
  logic bus_off_q;
  logic err_passive_q;
  // Interrupt flags
  logic rx_irq;
  logic tx_irq;
  logic err_irq;
  logic ovr_irq;
  logic epass_irq;
  logic alost_irq;
  logic berr_irq;

  assign ext = mode_cfg.extended_mode;
  assign rm  = mode_cfg.reset_mode;

  // Shared enables come from a different register in each mode
  assign ovr_en = ext ? mode_cfg.irq_en[3] : mode_cfg.mode.basic.overrun_ie;
  assign err_en = ext ? mode_cfg.irq_en[2] : mode_cfg.mode.basic.error_ie;
  assign tx_en  = ext ? mode_cfg.irq_en[1] : mode_cfg.mode.basic.transmit_ie;
  assign rx_en  = ext ? mode_cfg.irq_en[0] : mode_cfg.mode.basic.receive_ie;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      tbs_q          <= 1'b1;
      overrun_q      <= 1'b0;
      error_status_q <= 1'b0;
      bus_off_q      <= 1'b0;
      err_passive_q  <= 1'b0;
    end
    else
    begin
      tbs_q          <= status_flags.transmit_buffer_status;
      overrun_q      <= core_status.overrun;
      error_status_q <= core_status.error_status;
      bus_off_q      <= core_status.node_bus_off;
      err_passive_q  <= core_status.node_error_passive;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Interrupt sources
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      {berr_irq, alost_irq, epass_irq, ovr_irq, err_irq, tx_irq, rx_irq} <= '0;
    else
    begin
      if (core_status.overrun & ~overrun_q & ovr_en)
        ovr_irq <= 1'b1;
      else if (rm | read_irq)
        ovr_irq <= 1'b0;
      // Clear wins over a new transmit buffer edge
      if (rm | read_irq)
        tx_irq <= 1'b0;
      else if (status_flags.transmit_buffer_status & ~tbs_q & tx_en)
        tx_irq <= 1'b1;
      // Receive stays up until the buffer is released
      if (~core_status.info_empty & ~rx_irq & rx_en)
        rx_irq <= 1'b1;
      else if (rm | core_ctrl.release_buffer)
        rx_irq <= 1'b0;
      // Any change of error or bus off state, survives reset mode
      if (((core_status.error_status ^ error_status_q) |
           (core_status.node_bus_off ^ bus_off_q)) & err_en)
        err_irq <= 1'b1;
      else if (read_irq)
        err_irq <= 1'b0;
      if (core_status.set_bus_error_irq & mode_cfg.irq_en[7])
        berr_irq <= 1'b1;
      else if (rm | read_irq)
        berr_irq <= 1'b0;
      if (core_status.set_arbitration_lost_irq & mode_cfg.irq_en[6])
        alost_irq <= 1'b1;
      else if (rm | read_irq)
        alost_irq <= 1'b0;
      // Entering error passive, or going back to error active
      if (((core_status.node_error_passive & ~err_passive_q) |
           (~core_status.node_error_passive & err_passive_q &
            core_status.node_error_active)) & mode_cfg.irq_en[5])
        epass_irq <= 1'b1;
      else if (rm | read_irq)
        epass_irq <= 1'b0;
    end
  end

  assign irq_flags = {berr_irq, alost_irq, epass_irq, 1'b0,
                      ovr_irq, err_irq, tx_irq, rx_irq};

  // Line is released for at least one cycle after a read or release
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      irq_n <= 1'b1;
    else if (read_irq | core_ctrl.release_buffer)
      irq_n <= 1'b1;
    else if (|irq_flags)
      irq_n <= 1'b0;
  end

endmodule

// ==== logic/can_mode_regs.sv ====
`timescale 1ns/1ps
`include "can_regs_settings.svh"

module can_mode_regs
  import can_regs_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  host_wr_t     host_wr,
  input  core_status_t core_status,
  output mode_cfg_t    mode_cfg,
  output acc_filter_t  acc_filter
);

  mode_reg_u   mode_q;
  logic        cd_ext_q;
  logic        cd_bit3_q;
  logic [2:0]  cd_low_q;
  can_byte_t   irq_en_q;
  acc_filter_t acc_q;

  //////////////////////////////////////////////////////////////////////
  // Mode byte
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      mode_q <= `CAN_MODE_RST;
    else
    begin
      // Core forces reset mode, e.g. on bus off
      if (core_status.set_reset_mode)
        mode_q.basic.reset <= 1'b1;
      else if (host_wr.mode)
        mode_q.basic.reset <= host_wr.data[0];
      // Interrupt enables of the basic layout
      if (host_wr.mode_basic)
        {mode_q.basic.overrun_ie, mode_q.basic.error_ie,
         mode_q.basic.transmit_ie, mode_q.basic.receive_ie} <= host_wr.data[4:1];
      // Operating modes of the extended layout
      if (host_wr.mode_ext)
        {mode_q.ext.acc_filter, mode_q.ext.self_test,
         mode_q.ext.listen_only} <= host_wr.data[3:1];
    end
  end

  // Clock divider, interrupt enable and acceptance bytes
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cd_ext_q  <= 1'b0;
      cd_bit3_q <= 1'b0;
      cd_low_q  <= 3'b000;
      irq_en_q  <= '0;
      acc_q     <= '0;
    end
    else
    begin
      // Bit 7 picks the extended register map
      if (host_wr.clkdiv_hi)
        {cd_ext_q, cd_bit3_q} <= {host_wr.data[7], host_wr.data[3]};
      if (host_wr.clkdiv_lo)
        cd_low_q <= host_wr.data[2:0];
      if (host_wr.irq_en)
        irq_en_q <= host_wr.data;
      for (int i = 0; i < 4; i++)
      begin
        if (host_wr.acc_code[i])
          acc_q.code[i] <= host_wr.data;
        if (host_wr.acc_mask[i])
          acc_q.mask[i] <= host_wr.data;
      end
    end
  end

  always_comb
  begin
    mode_cfg.reset_mode = mode_q.basic.reset;
    mode_cfg.extended_mode = cd_ext_q;
    // Special modes only take effect in extended mode
    mode_cfg.listen_only_mode = cd_ext_q & mode_q.ext.listen_only;
    mode_cfg.self_test_mode = cd_ext_q & mode_q.ext.self_test;
    mode_cfg.acceptance_filter_mode = cd_ext_q & mode_q.ext.acc_filter;
    mode_cfg.mode = mode_q;
    mode_cfg.irq_en = irq_en_q;
    // Bits 6 to 4 are not implemented
    mode_cfg.clock_div = {cd_ext_q, 3'b000, cd_bit3_q, cd_low_q};
  end

  assign acc_filter = acc_q;

endmodule

// ==== logic/can_regs_pkg.sv ====
`include "can_regs_settings.svh"

package can_regs_pkg;

  typedef logic [`CAN_DATA_W-1:0] can_byte_t;

  // Write strobes, already qualified by address and mode
  typedef struct packed {
    logic       mode;
    logic       mode_basic;
    logic       mode_ext;
    logic       command;
    logic       irq_en;
    logic       clkdiv_lo;
    logic       clkdiv_hi;
    logic [3:0] acc_code;
    logic [3:0] acc_mask;
    can_byte_t  data;
  } host_wr_t;

  //////////////////////////////////////////////////////////////////////
  // Mode byte, seen through the basic or the extended layout
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [2:0] unused;
    logic       overrun_ie;
    logic       error_ie;
    logic       transmit_ie;
    logic       receive_ie;
    logic       reset;
  } mode_basic_t;

  typedef struct packed {
    logic [3:0] unused;
    logic       acc_filter;
    logic       self_test;
    logic       listen_only;
    logic       reset;
  } mode_ext_t;

  typedef union packed {
    mode_basic_t basic;
    mode_ext_t   ext;
  } mode_reg_u;

  // Mode controls plus the raw bytes needed for readback
  typedef struct packed {
    logic      reset_mode;
    logic      extended_mode;
    logic      listen_only_mode;
    logic      self_test_mode;
    logic      acceptance_filter_mode;
    mode_reg_u mode;
    can_byte_t irq_en;
    can_byte_t clock_div;
  } mode_cfg_t;

  typedef struct packed {
    can_byte_t [3:0] code;
    can_byte_t [3:0] mask;
  } acc_filter_t;

  // Conditions reported by the CAN core
  typedef struct packed {
    logic sample_point;
    logic transmitting;
    logic set_reset_mode;
    logic node_bus_off;
    logic error_status;
    logic transmit_status;
    logic receive_status;
    logic tx_successful;
    logic need_to_tx;
    logic overrun;
    logic info_empty;
    logic set_bus_error_irq;
    logic set_arbitration_lost_irq;
    logic node_error_passive;
    logic node_error_active;
    logic tx_state;
    logic tx_state_q;
  } core_status_t;

  typedef struct packed {
    logic tx_request;
    logic abort_tx;
    logic release_buffer;
    logic clear_data_overrun;
    logic self_rx_request;
    logic single_shot_transmission;
  } core_ctrl_t;

  typedef struct packed {
    logic transmission_complete;
    logic transmit_buffer_status;
    logic overrun_status;
    logic receive_buffer_status;
  } status_flags_t;

endpackage

// ==== logic/can_regs_settings.svh ====
`ifndef CAN_REGS_SETTINGS_SVH
`define CAN_REGS_SETTINGS_SVH

// Register width
`define CAN_DATA_W 8

// Addresses shared by both modes
`define CAN_ADDR_MODE 8'd0
`define CAN_ADDR_COMMAND 8'd1
`define CAN_ADDR_STATUS 8'd2
`define CAN_ADDR_IRQ 8'd3
`define CAN_ADDR_CLKDIV 8'd31

// Extended mode interrupt enable
`define CAN_ADDR_IRQ_EN 8'd4

// Acceptance code and mask 0 move in extended mode
`define CAN_ADDR_ACC_CODE0_BASIC 8'd4
`define CAN_ADDR_ACC_MASK0_BASIC 8'd5
`define CAN_ADDR_ACC_CODE0_EXT 8'd16
`define CAN_ADDR_ACC_MASK0_EXT 8'd20

// Mode register comes up with only the reset bit set
`define CAN_MODE_RST 8'h01

// Filler read back from unused basic mode locations
`define CAN_BASIC_FILL 8'hff

`endif

// ==== logic/can_regs_top.sv ====
`timescale 1ns/1ps
`include "can_regs_settings.svh"

module can_regs_top
  import can_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   re,
  input  logic                   we,
  input  logic [7:0]             addr_read,
  input  logic [7:0]             addr_write,
  input  logic [`CAN_DATA_W-1:0] data_in,
  output logic [`CAN_DATA_W-1:0] data_out,
  output logic                   irq_n,
  input  core_status_t           core_status,
  output core_ctrl_t             core_ctrl,
  output mode_cfg_t              mode_cfg,
  output acc_filter_t            acc_filter
);

  host_wr_t      host_wr;
  status_flags_t status_flags;
  logic [7:0]    irq_flags;
  logic          read_irq;

  // Host side decode and readback
  can_host_port u_host_port (
    .clk          (clk),
    .rst          (rst),
    .re           (re),
    .we           (we),
    .addr_read    (addr_read),
    .addr_write   (addr_write),
    .data_in      (data_in),
    .data_out     (data_out),
    .mode_cfg     (mode_cfg),
    .acc_filter   (acc_filter),
    .status_flags (status_flags),
    .core_status  (core_status),
    .irq_flags    (irq_flags),
    .host_wr      (host_wr),
    .read_irq     (read_irq)
  );

  can_mode_regs u_mode_regs (
    .clk         (clk),
    .rst         (rst),
    .host_wr     (host_wr),
    .core_status (core_status),
    .mode_cfg    (mode_cfg),
    .acc_filter  (acc_filter)
  );

  can_command_ctrl u_command_ctrl (
    .clk          (clk),
    .rst          (rst),
    .host_wr      (host_wr),
    .mode_cfg     (mode_cfg),
    .core_status  (core_status),
    .core_ctrl    (core_ctrl),
    .status_flags (status_flags)
  );

  // Interrupt flags and the irq_n line
  can_irq_ctrl u_irq_ctrl (
    .clk          (clk),
    .rst          (rst),
    .mode_cfg     (mode_cfg),
    .core_status  (core_status),
    .core_ctrl    (core_ctrl),
    .status_flags (status_flags),
    .read_irq     (read_irq),
    .irq_flags    (irq_flags),
    .irq_n        (irq_n)
  );

endmodule

// ==== project.f ====
+incdir+logic
logic/can_regs_pkg.sv
logic/can_host_port.sv
logic/can_mode_regs.sv
logic/can_command_ctrl.sv
logic/can_irq_ctrl.sv
logic/can_regs_top.sv
verification/tb_clock_gen.sv
verification/tb_can_regs.sv

// ==== verification/tb_can_regs.sv ====
`timescale 1ns/1ps
`include "can_regs_settings.svh"

module tb_can_regs
  import can_regs_pkg::*;
();

  localparam int RAND_WRITES = 16;
  localparam int MODE_ROUNDS = 4;
  // Rough cycle count of all tests, doubled for the watchdog
  localparam int TEST_CYCLES = 10 + (2 * RAND_WRITES + 12) * 4 + 3 * 30 + MODE_ROUNDS * 2 * 10;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 100;

  logic         clk;
  logic         rst;
  logic         re;
  logic         we;
  logic [7:0]   addr_read;
  logic [7:0]   addr_write;
  logic [7:0]   data_in;
  logic [7:0]   data_out;
  logic         irq_n;
  core_status_t core_status;
  core_ctrl_t   core_ctrl;
  mode_cfg_t    mode_cfg;
  acc_filter_t  acc_filter;

  integer seed;
  int     errors;
  int     checks;
  int     test_errors;

  // Reference model state
  logic [7:0]  m_mode;
  logic [7:0]  m_cd;
  logic [7:0]  m_ier;
  acc_filter_t m_acc;
  logic [3:0]  m_flags;
  logic [7:0]  m_irq;

  tb_clock_gen #(.PERIOD_NS(100.0)) u_clock_gen (.clk(clk));

  can_regs_top u_can_regs_top (
    .clk         (clk),
    .rst         (rst),
    .re          (re),
    .we          (we),
    .addr_read   (addr_read),
    .addr_write  (addr_write),
    .data_in     (data_in),
    .data_out    (data_out),
    .irq_n       (irq_n),
    .core_status (core_status),
    .core_ctrl   (core_ctrl),
    .mode_cfg    (mode_cfg),
    .acc_filter  (acc_filter)
  );

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////
  task automatic model_write(input logic [7:0] a, input logic [7:0] d);
    logic rm;
    logic ext;
    begin
      rm = m_mode[0];
      ext = m_cd[7];
      // Same byte seen through two layouts
      if (a == `CAN_ADDR_MODE)
      begin
        if (!ext)
          m_mode[4:1] = d[4:1];
        else if (rm)
          m_mode[3:1] = d[3:1];
        m_mode[0] = d[0];
      end
      // Bits 7 and 3 locked outside reset mode
      if (a == `CAN_ADDR_CLKDIV)
      begin
        if (rm)
        begin
          m_cd[7] = d[7];
          m_cd[3] = d[3];
        end
        m_cd[2:0] = d[2:0];
      end
      if (ext && a == `CAN_ADDR_IRQ_EN)
        m_ier = d;
      if (rm && !ext && a == `CAN_ADDR_ACC_CODE0_BASIC)
        m_acc.code[0] = d;
      if (rm && !ext && a == `CAN_ADDR_ACC_MASK0_BASIC)
        m_acc.mask[0] = d;
      if (rm && ext && a >= 8'd16 && a <= 8'd19)
        m_acc.code[a[1:0]] = d;
      if (rm && ext && a >= 8'd20 && a <= 8'd23)
        m_acc.mask[a[1:0]] = d;
    end
  endtask

  function automatic logic [7:0] expected_read(input logic [7:0] a);
    logic [7:0] status;
    logic [7:0] r;
    begin
      // Core status bits stay low in this bench
      status = {4'h0, m_flags};
      r = 8'h00;
      if (m_cd[7])
      begin
        case (a)
          `CAN_ADDR_MODE:   r = {4'h0, m_mode[3:0]};
          `CAN_ADDR_STATUS: r = status;
          `CAN_ADDR_IRQ:    r = m_irq;
          `CAN_ADDR_IRQ_EN: r = m_ier;
          `CAN_ADDR_CLKDIV: r = m_cd;
          default:
          begin
            if (a >= 8'd16 && a <= 8'd19)
              r = m_acc.code[a[1:0]];
            else if (a >= 8'd20 && a <= 8'd23)
              r = m_acc.mask[a[1:0]];
          end
        endcase
      end
      else
      begin
        case (a)
          `CAN_ADDR_MODE:            r = {3'b001, m_mode[4:0]};
          `CAN_ADDR_COMMAND:         r = `CAN_BASIC_FILL;
          `CAN_ADDR_STATUS:          r = status;
          `CAN_ADDR_IRQ:             r = {4'he, m_irq[3:0]};
          `CAN_ADDR_ACC_CODE0_BASIC: r = m_mode[0] ? m_acc.code[0] : `CAN_BASIC_FILL;
          `CAN_ADDR_ACC_MASK0_BASIC: r = m_mode[0] ? m_acc.mask[0] : `CAN_BASIC_FILL;
          `CAN_ADDR_CLKDIV:          r = m_cd;
          default:
          begin
            if (a >= 8'd10 && a <= 8'd19)
              r = `CAN_BASIC_FILL;
          end
        endcase
      end
      return r;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Host access and checking
  ////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    begin
      checks++;
      assert (actual === expected)
      else
      begin
        $display("Fail %s expected %0h actual %0h", name, expected, actual);
        errors++;
      end
    end
  endtask

  // Write lands at the second rising edge
  task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
    begin
      @(posedge clk);
      we <= 1'b1;
      addr_write <= a;
      data_in <= d;
      @(posedge clk);
      we <= 1'b0;
      model_write(a, d);
    end
  endtask

  // Read data sampled mid cycle
  task automatic read_and_check(input logic [7:0] a);
    logic [7:0] got;
    begin
      @(posedge clk);
      re <= 1'b1;
      addr_read <= a;
      @(negedge clk);
      got = data_out;
      check_value($sformatf("data_out @%02h", a), expected_read(a), got);
      @(posedge clk);
      re <= 1'b0;
      // Interrupt read clears all flags but receive
      if (a == `CAN_ADDR_IRQ)
        m_irq = m_irq & 8'h01;
    end
  endtask

  task automatic report_test(input string name);
    begin
      $display("Test %s done, %0d errors", name, errors - test_errors);
      test_errors = errors;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////
  task automatic check_reset_values();
    begin
      read_and_check(`CAN_ADDR_MODE);
      read_and_check(`CAN_ADDR_CLKDIV);
      read_and_check(`CAN_ADDR_STATUS);
      @(negedge clk);
      check_value("irq_n", 1'b1, irq_n);
      // No command pending out of reset
      check_value("core_ctrl", 64'h0, core_ctrl);
      check_value("mode_cfg.reset_mode", 1'b1, mode_cfg.reset_mode);
      check_value("mode_cfg.extended_mode", 1'b0, mode_cfg.extended_mode);
      report_test("reset");
    end
  endtask

  task automatic run_register_writes();
    logic [31:0] r;
    logic [15:0] idx;
    logic [7:0]  a;
    logic [7:0]  d;
    begin
      // Basic map, bit 7 of the divider kept low
      repeat (RAND_WRITES)
      begin
        r = $random(seed);
        idx = r[15:0] % 16'd3;
        a = (idx == 16'd2) ? `CAN_ADDR_CLKDIV : 8'd4 + idx[7:0];
        d = r[23:16];
        if (a == `CAN_ADDR_CLKDIV)
          d[7] = 1'b0;
        write_reg(a, d);
        read_and_check(a);
      end
      check_value("acc_filter", m_acc, acc_filter);
      // Move to the extended map
      r = $random(seed);
      write_reg(`CAN_ADDR_CLKDIV, 8'h80 | r[7:0]);
      read_and_check(`CAN_ADDR_CLKDIV);
      repeat (RAND_WRITES)
      begin
        r = $random(seed);
        idx = r[15:0] % 16'd10;
        a = (idx == 16'd0) ? 8'd4 : (idx == 16'd9) ? 8'd31 : 8'd15 + idx[7:0];
        d = r[23:16];
        if (a == `CAN_ADDR_CLKDIV)
          d[7] = 1'b1;
        write_reg(a, d);
        read_and_check(a);
      end
      check_value("acc_filter", m_acc, acc_filter);
      // Leave reset mode, acceptance bytes now locked
      write_reg(`CAN_ADDR_MODE, 8'h00);
      repeat (8)
      begin
        r = $random(seed);
        a = 8'd16 + {5'd0, r[2:0]};
        write_reg(a, r[15:8]);
        read_and_check(a);
      end
      check_value("acc_filter", m_acc, acc_filter);
      report_test("register writes");
    end
  endtask

  task automatic run_tx_request();
    begin
      write_reg(`CAN_ADDR_IRQ_EN, 8'h00);
      @(posedge clk);
      core_status.need_to_tx <= 1'b1;
      write_reg(`CAN_ADDR_COMMAND, 8'h01);
      @(negedge clk);
      check_value("core_ctrl.tx_request", 1'b1, core_ctrl.tx_request);
      // Complete and buffer flags drop with the request
      m_flags[3] = 1'b0;
      m_flags[2] = 1'b0;
      read_and_check(`CAN_ADDR_STATUS);
      @(posedge clk);
      core_status.sample_point <= 1'b1;
      @(posedge clk);
      core_status.sample_point <= 1'b0;
      @(negedge clk);
      check_value("core_ctrl.tx_request", 1'b0, core_ctrl.tx_request);
      @(posedge clk);
      core_status.need_to_tx <= 1'b0;
      m_flags[2] = 1'b1;
      read_and_check(`CAN_ADDR_STATUS);
      report_test("tx request");
    end
  endtask

  task automatic run_rx_interrupt();
    begin
      write_reg(`CAN_ADDR_IRQ_EN, 8'h01);
      @(posedge clk);
      core_status.info_empty <= 1'b0;
      // Flag edge then interrupt line
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_value("irq_n", 1'b0, irq_n);
      m_flags[0] = 1'b1;
      m_irq[0] = 1'b1;
      read_and_check(`CAN_ADDR_STATUS);
      read_and_check(`CAN_ADDR_IRQ);
      @(posedge clk);
      core_status.info_empty <= 1'b1;
      @(negedge clk);
      check_value("irq_n", 1'b0, irq_n);
      // Release buffer command, high for a single cycle
      write_reg(`CAN_ADDR_COMMAND, 8'h04);
      @(negedge clk);
      check_value("core_ctrl.release_buffer", 1'b1, core_ctrl.release_buffer);
      @(posedge clk);
      @(negedge clk);
      check_value("core_ctrl.release_buffer", 1'b0, core_ctrl.release_buffer);
      check_value("irq_n", 1'b1, irq_n);
      m_flags[0] = 1'b0;
      m_irq[0] = 1'b0;
      read_and_check(`CAN_ADDR_STATUS);
      read_and_check(`CAN_ADDR_IRQ);
      report_test("rx interrupt");
    end
  endtask

  task automatic run_overrun();
    begin
      write_reg(`CAN_ADDR_IRQ_EN, 8'h08);
      @(posedge clk);
      core_status.overrun <= 1'b1;
      m_flags[1] = 1'b1;
      m_irq[3] = 1'b1;
      read_and_check(`CAN_ADDR_STATUS);
      @(posedge clk);
      core_status.overrun <= 1'b0;
      // Clear data overrun command
      write_reg(`CAN_ADDR_COMMAND, 8'h08);
      @(negedge clk);
      check_value("core_ctrl.clear_data_overrun", 1'b1, core_ctrl.clear_data_overrun);
      m_flags[1] = 1'b0;
      read_and_check(`CAN_ADDR_STATUS);
      read_and_check(`CAN_ADDR_IRQ);
      read_and_check(`CAN_ADDR_IRQ);
      @(posedge clk);
      @(negedge clk);
      check_value("irq_n", 1'b1, irq_n);
      report_test("overrun");
    end
  endtask

  task automatic run_mode_decode();
    logic [31:0] r;
    logic        ext;
    begin
      repeat (MODE_ROUNDS)
      begin
        for (int e = 0; e < 2; e++)
        begin
          r = $random(seed);
          // Reset mode first so the divider bit 7 is writable
          write_reg(`CAN_ADDR_MODE, 8'h01);
          write_reg(`CAN_ADDR_CLKDIV, {e[0], r[14:8]});
          write_reg(`CAN_ADDR_MODE, r[7:0]);
          @(negedge clk);
          ext = m_cd[7];
          check_value("mode_cfg.extended_mode", ext, mode_cfg.extended_mode);
          check_value("mode_cfg.reset_mode", m_mode[0], mode_cfg.reset_mode);
          check_value("mode_cfg.listen_only_mode", ext & m_mode[1],
                      mode_cfg.listen_only_mode);
          check_value("mode_cfg.self_test_mode", ext & m_mode[2],
                      mode_cfg.self_test_mode);
          check_value("mode_cfg.acceptance_filter_mode", ext & m_mode[3],
                      mode_cfg.acceptance_filter_mode);
          read_and_check(`CAN_ADDR_MODE);
        end
      end
      report_test("mode decode");
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////
  initial
  begin
    seed = 32'h10d6;
    errors = 0;
    checks = 0;
    test_errors = 0;
    rst <= 1'b1;
    re <= 1'b0;
    we <= 1'b0;
    addr_read <= 8'h00;
    addr_write <= 8'h00;
    data_in <= 8'h00;
    core_status <= '0;
    // Receive buffer starts empty
    core_status.info_empty <= 1'b1;
    m_mode = `CAN_MODE_RST;
    m_cd = 8'h00;
    m_ier = 8'h00;
    m_acc = '0;
    m_flags = 4'b1100;
    m_irq = 8'h00;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    check_reset_values();
    run_register_writes();
    run_tx_request();
    run_rx_interrupt();
    run_overrun();
    run_mode_decode();
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog sized from the test lengths
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

// Free running clock for the testbench
module tb_clock_gen #(
  parameter real PERIOD_NS = 100.0
)
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    // Half period per toggle
    forever
      #(PERIOD_NS / 2.0) clk = ~clk;
  end

endmodule
